/* logic/serdes_pkg.sv */
`default_nettype none

package serdes_pkg;

	//////////////////// stream word

	localparam int data_width = 32;
	localparam int keep_width = data_width / 8;  // one keep bit per byte

	//////////////////// beat timing

	// a beat is clk_ratio ioclk cycles, one bit per lane per cycle
	localparam int clk_ratio   = 4;
	localparam int phase_width = $clog2(clk_ratio);

	localparam logic [phase_width-1:0] last_phase = phase_width'(clk_ratio - 1);

	//////////////////// lane map

	// each data lane carries one nibble of the word
	localparam int data_lanes = data_width / clk_ratio;

	// keep travels on its own lane right after the data lanes
	localparam int keep_lane = data_lanes;
	localparam int ctrl_lane = data_lanes + 1;
	localparam int lanes     = data_lanes + 2;

	// control nibble layout, bit 3 is spare
	localparam int ctrl_tvalid_bit = 0;
	localparam int ctrl_tlast_bit  = 1;
	localparam int ctrl_tready_bit = 2;

endpackage

`default_nettype wire

/* logic/serdes_reg_pkg.sv */
`default_nettype none

package serdes_reg_pkg;

	//////////////////// register map

	localparam int wb_addr_width = 4;  // word address

	localparam logic [wb_addr_width-1:0] ctrl_addr = wb_addr_width'(0);

	// control register fields
	localparam int rxen_bit = 0;
	localparam int txen_bit = 1;

	// slave cycle state, ack lasts one cycle
	typedef enum logic {
		idle,
		ack
	} bus_state_t;

endpackage

`default_nettype wire

/* logic/serdes_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module serdes_regs (
	input  wire                                        ioclk,
	input  wire                                        axis_rst_n,
	input  wire                                        wb_cyc,
	input  wire                                        wb_stb,
	input  wire                                        wb_we,
	input  wire  [serdes_reg_pkg::wb_addr_width-1:0]   wb_adr,
	input  wire  [serdes_pkg::data_width-1:0]          wb_dat_w,
	input  wire  [serdes_pkg::keep_width-1:0]          wb_sel,
	output logic [serdes_pkg::data_width-1:0]          wb_dat_r,
	output logic                                       wb_ack,
	output logic                                       rxen_ctl,
	output logic                                       txen_ctl
);

	serdes_reg_pkg::bus_state_t state;

	logic                              cyc_start;  // first cycle of a bus cycle
	logic                              ctrl_hit;
	logic [serdes_pkg::data_width-1:0] ctrl_word;

	assign cyc_start = wb_cyc && wb_stb && (state == serdes_reg_pkg::idle);
	assign ctrl_hit  = (wb_adr == serdes_reg_pkg::ctrl_addr);
	assign wb_ack    = (state == serdes_reg_pkg::ack);

	always_ff @(posedge ioclk or negedge axis_rst_n) begin
		if (!axis_rst_n) begin
			state <= serdes_reg_pkg::idle;
		end else begin
			case (state)
				serdes_reg_pkg::idle: begin
					if (wb_cyc && wb_stb) begin
						state <= serdes_reg_pkg::ack;
					end
				end
				default: state <= serdes_reg_pkg::idle;  // back to idle after one ack
			endcase
		end
	end

	//////////////////// control register

	always_ff @(posedge ioclk or negedge axis_rst_n) begin
		if (!axis_rst_n) begin
			rxen_ctl <= 1'b0;
			txen_ctl <= 1'b0;
		end else if (cyc_start && wb_we && ctrl_hit && wb_sel[0]) begin
			rxen_ctl <= wb_dat_w[serdes_reg_pkg::rxen_bit];
			txen_ctl <= wb_dat_w[serdes_reg_pkg::txen_bit];
		end
	end

	// read back, upper bits zero
	always_comb begin
		ctrl_word = '0;
		ctrl_word[serdes_reg_pkg::rxen_bit] = rxen_ctl;
		ctrl_word[serdes_reg_pkg::txen_bit] = txen_ctl;
	end

	assign wb_dat_r = ctrl_hit ? ctrl_word : '0;  // unmapped addresses read zero

endmodule

`default_nettype wire

/* logic/serdes_link_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module serdes_link_ctrl (
	input  wire                                  ioclk,
	input  wire                                  axis_rst_n,
	input  wire                                  rxen_ctl,
	input  wire                                  txen_ctl,
	input  wire                                  rx_frame_seen,
	output logic [serdes_pkg::phase_width-1:0]   phase,
	output logic                                 tx_en,
	output logic                                 rx_en
);

	logic beat_end;  // last ioclk cycle of the beat

	assign beat_end = (phase == serdes_pkg::last_phase);

	//////////////////// beat phase

	// free running, stands in for the core clock
	always_ff @(posedge ioclk or negedge axis_rst_n) begin
		if (!axis_rst_n) begin
			phase <= '0;
		end else if (beat_end) begin
			phase <= '0;
		end else begin
			phase <= phase + 1'b1;
		end
	end

	//////////////////// bring-up

	// receive side opens as soon as software asks, and stays open
	always_ff @(posedge ioclk or negedge axis_rst_n) begin
		if (!axis_rst_n) begin
			rx_en <= 1'b0;
		end else if (rxen_ctl) begin
			rx_en <= 1'b1;
		end
	end

	// transmit starts on a beat boundary, either from software or
	// because the far side is already sending frames to us
	always_ff @(posedge ioclk or negedge axis_rst_n) begin
		if (!axis_rst_n) begin
			tx_en <= 1'b0;
		end else if (beat_end && (txen_ctl || rx_frame_seen)) begin
			tx_en <= 1'b1;  // sticky
		end
	end

endmodule

`default_nettype wire

/* logic/serdes_tx.sv */
`timescale 1ns/10ps
`default_nettype none

module serdes_tx (
	input  wire                                  ioclk,
	input  wire                                  axis_rst_n,
	input  wire  [serdes_pkg::phase_width-1:0]   phase,
	input  wire                                  tx_en,
	input  wire                                  is_as_tready,
	input  wire  [serdes_pkg::data_width-1:0]    as_is_tdata,
	input  wire  [serdes_pkg::keep_width-1:0]    as_is_tkeep,
	input  wire                                  as_is_tlast,
	input  wire                                  as_is_tvalid,
	input  wire                                  as_is_tready,
	output logic [serdes_pkg::lanes-1:0]         serial_txd
);

	localparam int buf_width = serdes_pkg::lanes * serdes_pkg::clk_ratio;

	logic [serdes_pkg::data_width-1:0] data_buf;
	logic [serdes_pkg::keep_width-1:0] keep_buf;
	logic [serdes_pkg::clk_ratio-1:0]  ctrl_buf;
	logic [serdes_pkg::clk_ratio-1:0]  ctrl_next;
	logic [buf_width-1:0]              beat_buf;  // lane n owns bits [4n+3:4n]
	logic                              beat_end;
	logic                              accept;

	assign beat_end = (phase == serdes_pkg::last_phase);
	assign accept   = as_is_tvalid && is_as_tready;  // far side ready is low until tx_en

	// control nibble for the next beat
	always_comb begin
		ctrl_next = '0;
		ctrl_next[serdes_pkg::ctrl_tvalid_bit] = accept;
		ctrl_next[serdes_pkg::ctrl_tlast_bit]  = as_is_tlast;
		ctrl_next[serdes_pkg::ctrl_tready_bit] = as_is_tready;  // our readiness to the far side
	end

	//////////////////// beat buffer

	// the offered word is loaded at every beat end
	always_ff @(posedge ioclk) begin
		if (beat_end) begin
			data_buf <= as_is_tdata;
			keep_buf <= as_is_tkeep;
		end
	end

	always_ff @(posedge ioclk or negedge axis_rst_n) begin
		if (!axis_rst_n) begin
			ctrl_buf <= '0;
		end else if (beat_end) begin
			ctrl_buf <= ctrl_next;
		end
	end

	assign beat_buf = {ctrl_buf, keep_buf, data_buf};

	//////////////////// lane output

	// lsb of each nibble goes out first, at phase 0
	always_comb begin
		for (int i = 0; i < serdes_pkg::lanes; i++) begin
			serial_txd[i] = beat_buf[i * serdes_pkg::clk_ratio + int'(phase)] & tx_en;
		end
	end

endmodule

`default_nettype wire

/* logic/serdes_rx_lane.sv */
`timescale 1ns/10ps
`default_nettype none

module serdes_rx_lane (
	input  wire                                  ioclk,
	input  wire                                  axis_rst_n,
	input  wire                                  rx_en,
	input  wire  [serdes_pkg::phase_width-1:0]   phase,
	input  wire                                  serial_bit,
	output logic [serdes_pkg::clk_ratio-1:0]     lane_nibble,
	output logic                                 lane_done
);

	logic [serdes_pkg::clk_ratio-2:0] shift_q;   // first bits of the current beat
	logic [serdes_pkg::clk_ratio-1:0] nibble_q;  // completed nibble, retimed one beat

	// shift in during the beat, hand the previous nibble on at its end
	always_ff @(posedge ioclk or negedge axis_rst_n) begin
		if (!axis_rst_n) begin
			shift_q     <= '0;
			nibble_q    <= '0;
			lane_nibble <= '0;
			lane_done   <= 1'b0;
		end else begin
			lane_done <= 1'b0;
			if (rx_en) begin
				shift_q <= {serial_bit, shift_q[serdes_pkg::clk_ratio-2:1]};  // lsb arrives first
				if (phase == serdes_pkg::last_phase) begin
					nibble_q    <= {serial_bit, shift_q};
					lane_nibble <= nibble_q;
					lane_done   <= 1'b1;  // one pulse per beat
				end
			end
		end
	end

endmodule

`default_nettype wire

/* logic/serdes_rx_merge.sv */
`timescale 1ns/10ps
`default_nettype none

module serdes_rx_merge (
	input  wire                                                      ioclk,
	input  wire                                                      axis_rst_n,
	input  wire                                                      tx_en,
	input  wire  [serdes_pkg::lanes*serdes_pkg::clk_ratio-1:0]       lane_nibbles,
	input  wire  [serdes_pkg::lanes-1:0]                             lane_done,
	output logic [serdes_pkg::data_width-1:0]                        is_as_tdata,
	output logic [serdes_pkg::keep_width-1:0]                        is_as_tkeep,
	output logic                                                     is_as_tlast,
	output logic                                                     is_as_tvalid,
	output logic                                                     is_as_tready,
	output logic                                                     rx_frame_seen
);

	logic                             frame_done;  // every lane delivered its nibble
	logic [serdes_pkg::clk_ratio-1:0] ctrl_nib;

	assign frame_done = &lane_done;
	assign ctrl_nib   = lane_nibbles[serdes_pkg::ctrl_lane*serdes_pkg::clk_ratio
			+: serdes_pkg::clk_ratio];

	//////////////////// stream out

	assign is_as_tdata  = lane_nibbles[serdes_pkg::data_width-1:0];
	assign is_as_tkeep  = lane_nibbles[serdes_pkg::keep_lane*serdes_pkg::clk_ratio
			+: serdes_pkg::keep_width];
	assign is_as_tlast  = ctrl_nib[serdes_pkg::ctrl_tlast_bit];
	assign is_as_tvalid = frame_done && ctrl_nib[serdes_pkg::ctrl_tvalid_bit];  // one cycle per beat

	//////////////////// flow control

	always_ff @(posedge ioclk or negedge axis_rst_n) begin
		if (!axis_rst_n) begin
			rx_frame_seen <= 1'b0;
		end else if (is_as_tvalid) begin
			rx_frame_seen <= 1'b1;
		end
	end

	// ready before the first frame keeps both ends from waiting on each other
	always_ff @(posedge ioclk or negedge axis_rst_n) begin
		if (!axis_rst_n) begin
			is_as_tready <= 1'b0;
		end else if (!tx_en) begin
			is_as_tready <= 1'b0;
		end else if (frame_done && (rx_frame_seen || is_as_tvalid)) begin
			is_as_tready <= ctrl_nib[serdes_pkg::ctrl_tready_bit];  // far side readiness
		end else if (!rx_frame_seen) begin
			is_as_tready <= 1'b1;
		end
	end

endmodule

`default_nettype wire

/* logic/io_serdes.sv */
`timescale 1ns/10ps
`default_nettype none

module io_serdes (
	input  wire                                        ioclk,
	input  wire                                        axis_rst_n,
	// wishbone slave
	input  wire                                        wb_cyc,
	input  wire                                        wb_stb,
	input  wire                                        wb_we,
	input  wire  [serdes_reg_pkg::wb_addr_width-1:0]   wb_adr,
	input  wire  [serdes_pkg::data_width-1:0]          wb_dat_w,
	input  wire  [serdes_pkg::keep_width-1:0]          wb_sel,
	output logic [serdes_pkg::data_width-1:0]          wb_dat_r,
	output logic                                       wb_ack,
	// stream in, toward the far side
	input  wire  [serdes_pkg::data_width-1:0]          as_is_tdata,
	input  wire  [serdes_pkg::keep_width-1:0]          as_is_tkeep,
	input  wire                                        as_is_tlast,
	input  wire                                        as_is_tvalid,
	input  wire                                        as_is_tready,
	// stream out, from the far side
	output logic [serdes_pkg::data_width-1:0]          is_as_tdata,
	output logic [serdes_pkg::keep_width-1:0]          is_as_tkeep,
	output logic                                       is_as_tlast,
	output logic                                       is_as_tvalid,
	output logic                                       is_as_tready,
	// serial lanes
	output logic [serdes_pkg::lanes-1:0]               serial_txd,
	input  wire  [serdes_pkg::lanes-1:0]               serial_rxd
);

	logic                                                rxen_ctl;
	logic                                                txen_ctl;
	logic [serdes_pkg::phase_width-1:0]                  phase;
	logic                                                tx_en;
	logic                                                rx_en;
	logic                                                rx_frame_seen;
	logic [serdes_pkg::lanes*serdes_pkg::clk_ratio-1:0]  lane_nibbles;
	logic [serdes_pkg::lanes-1:0]                        lane_done;

	serdes_regs i_regs (
		.ioclk      (ioclk),
		.axis_rst_n (axis_rst_n),
		.wb_cyc     (wb_cyc),
		.wb_stb     (wb_stb),
		.wb_we      (wb_we),
		.wb_adr     (wb_adr),
		.wb_dat_w   (wb_dat_w),
		.wb_sel     (wb_sel),
		.wb_dat_r   (wb_dat_r),
		.wb_ack     (wb_ack),
		.rxen_ctl   (rxen_ctl),
		.txen_ctl   (txen_ctl)
	);

	serdes_link_ctrl i_link_ctrl (
		.ioclk         (ioclk),
		.axis_rst_n    (axis_rst_n),
		.rxen_ctl      (rxen_ctl),
		.txen_ctl      (txen_ctl),
		.rx_frame_seen (rx_frame_seen),
		.phase         (phase),
		.tx_en         (tx_en),
		.rx_en         (rx_en)
	);

	//////////////////// transmit

	serdes_tx i_tx (
		.ioclk        (ioclk),
		.axis_rst_n   (axis_rst_n),
		.phase        (phase),
		.tx_en        (tx_en),
		.is_as_tready (is_as_tready),
		.as_is_tdata  (as_is_tdata),
		.as_is_tkeep  (as_is_tkeep),
		.as_is_tlast  (as_is_tlast),
		.as_is_tvalid (as_is_tvalid),
		.as_is_tready (as_is_tready),
		.serial_txd   (serial_txd)
	);

	//////////////////// receive

	for (genvar g = 0; g < serdes_pkg::lanes; g++) begin : g_rx_lane
		serdes_rx_lane i_rx_lane (
			.ioclk       (ioclk),
			.axis_rst_n  (axis_rst_n),
			.rx_en       (rx_en),
			.phase       (phase),
			.serial_bit  (serial_rxd[g]),
			.lane_nibble (lane_nibbles[g*serdes_pkg::clk_ratio +: serdes_pkg::clk_ratio]),
			.lane_done   (lane_done[g])
		);
	end

	serdes_rx_merge i_rx_merge (
		.ioclk         (ioclk),
		.axis_rst_n    (axis_rst_n),
		.tx_en         (tx_en),
		.lane_nibbles  (lane_nibbles),
		.lane_done     (lane_done),
		.is_as_tdata   (is_as_tdata),
		.is_as_tkeep   (is_as_tkeep),
		.is_as_tlast   (is_as_tlast),
		.is_as_tvalid  (is_as_tvalid),
		.is_as_tready  (is_as_tready),
		.rx_frame_seen (rx_frame_seen)
	);

endmodule

`default_nettype wire

/* sim/io_serdes_clkgen.sv */
`timescale 1ns/10ps
`default_nettype none

module io_serdes_clkgen (
	output logic ioclk,
	output logic axis_rst_n
);

	localparam time half_period = 10ns;  // 20 ns ioclk
	localparam int  rst_cycles  = 4;

	initial begin
		ioclk = 1'b0;
		forever #(half_period) ioclk = ~ioclk;
	end

	initial begin
		axis_rst_n = 1'b0;
		repeat (rst_cycles) @(posedge ioclk);
		@(negedge ioclk);
		axis_rst_n = 1'b1;  // release away from the active edge
	end

endmodule

`default_nettype wire

/* sim/io_serdes_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module io_serdes_checker (
	input wire                                       ioclk,
	input wire                                       axis_rst_n,
	input wire                                       wb_cyc,
	input wire                                       wb_stb,
	input wire                                       wb_we,
	input wire [serdes_reg_pkg::wb_addr_width-1:0]   wb_adr,
	input wire [serdes_pkg::data_width-1:0]          wb_dat_w,
	input wire [serdes_pkg::keep_width-1:0]          wb_sel,
	input wire                                       wb_ack,
	input wire                                       is_as_tvalid,
	input wire                                       is_as_tready,
	input wire [serdes_pkg::lanes-1:0]               serial_txd
);

	logic txen_written;  // software has asked for transmit

	always_ff @(posedge ioclk or negedge axis_rst_n) begin
		if (!axis_rst_n) begin
			txen_written <= 1'b0;
		end else if (wb_cyc && wb_stb && wb_we && wb_sel[0] &&
				wb_adr == serdes_reg_pkg::ctrl_addr &&
				wb_dat_w[serdes_reg_pkg::txen_bit]) begin
			txen_written <= 1'b1;
		end
	end

	//////////////////// reset

	// outputs are quiet while reset is held
	reset_quiet: assert property (@(posedge ioclk)
		!axis_rst_n |-> (!wb_ack && !is_as_tvalid && !is_as_tready && serial_txd == '0))
		else $error("outputs not idle during reset");

	// lanes stay silent until software enables transmit
	txd_idle: assert property (@(posedge ioclk) disable iff (!axis_rst_n)
		!txen_written |-> serial_txd == '0)
		else $error("serial_txd active before txen was written");

	ready_idle: assert property (@(posedge ioclk) disable iff (!axis_rst_n)
		!txen_written |-> !is_as_tready)
		else $error("is_as_tready high before txen was written");

	//////////////////// wishbone

	ack_follows: assert property (@(posedge ioclk) disable iff (!axis_rst_n)
		(wb_cyc && wb_stb && !wb_ack) |=> wb_ack)
		else $error("wb_ack missing after request");

	ack_single: assert property (@(posedge ioclk) disable iff (!axis_rst_n)
		wb_ack |=> !wb_ack)
		else $error("wb_ack longer than one cycle");

	//////////////////// stream

	tvalid_strobe: assert property (@(posedge ioclk) disable iff (!axis_rst_n)
		is_as_tvalid |=> !is_as_tvalid)
		else $error("is_as_tvalid longer than one cycle");

endmodule

bind io_serdes io_serdes_checker i_checker (
	.ioclk        (ioclk),
	.axis_rst_n   (axis_rst_n),
	.wb_cyc       (wb_cyc),
	.wb_stb       (wb_stb),
	.wb_we        (wb_we),
	.wb_adr       (wb_adr),
	.wb_dat_w     (wb_dat_w),
	.wb_sel       (wb_sel),
	.wb_ack       (wb_ack),
	.is_as_tvalid (is_as_tvalid),
	.is_as_tready (is_as_tready),
	.serial_txd   (serial_txd)
);

`default_nettype wire

/* sim/io_serdes_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module io_serdes_tb;

	localparam int latency    = 8;   // acceptance to strobe, in ioclk cycles
	localparam int fall_limit = 12;  // one beat to capture plus eight cycles in flight
	localparam int wait_limit = 200;

	logic                                      ioclk;
	logic                                      axis_rst_n;
	logic                                      wb_cyc;
	logic                                      wb_stb;
	logic                                      wb_we;
	logic [serdes_reg_pkg::wb_addr_width-1:0]  wb_adr;
	logic [serdes_pkg::data_width-1:0]         wb_dat_w;
	logic [serdes_pkg::keep_width-1:0]         wb_sel;
	logic [serdes_pkg::data_width-1:0]         wb_dat_r;
	logic                                      wb_ack;
	logic [serdes_pkg::data_width-1:0]         as_is_tdata;
	logic [serdes_pkg::keep_width-1:0]         as_is_tkeep;
	logic                                      as_is_tlast;
	logic                                      as_is_tvalid;
	logic                                      as_is_tready;
	logic [serdes_pkg::data_width-1:0]         is_as_tdata;
	logic [serdes_pkg::keep_width-1:0]         is_as_tkeep;
	logic                                      is_as_tlast;
	logic                                      is_as_tvalid;
	logic                                      is_as_tready;
	logic [serdes_pkg::lanes-1:0]              serial_loop;

	logic [serdes_pkg::data_width-1:0] exp_data[$];
	logic [serdes_pkg::keep_width-1:0] exp_keep[$];
	logic                              exp_last[$];
	int                                exp_cycle[$];
	int                                cycle;
	int                                accepted;
	string                             cur_test;
	logic [serdes_pkg::data_width-1:0] rd_data;
	int unsigned                       seed_val;

	io_serdes_clkgen i_clkgen (
		.ioclk      (ioclk),
		.axis_rst_n (axis_rst_n)
	);

	io_serdes i_io_serdes (
		.ioclk        (ioclk),
		.axis_rst_n   (axis_rst_n),
		.wb_cyc       (wb_cyc),
		.wb_stb       (wb_stb),
		.wb_we        (wb_we),
		.wb_adr       (wb_adr),
		.wb_dat_w     (wb_dat_w),
		.wb_sel       (wb_sel),
		.wb_dat_r     (wb_dat_r),
		.wb_ack       (wb_ack),
		.as_is_tdata  (as_is_tdata),
		.as_is_tkeep  (as_is_tkeep),
		.as_is_tlast  (as_is_tlast),
		.as_is_tvalid (as_is_tvalid),
		.as_is_tready (as_is_tready),
		.is_as_tdata  (is_as_tdata),
		.is_as_tkeep  (is_as_tkeep),
		.is_as_tlast  (is_as_tlast),
		.is_as_tvalid (is_as_tvalid),
		.is_as_tready (is_as_tready),
		.serial_txd   (serial_loop),
		.serial_rxd   (serial_loop)  // loopback
	);

	//////////////////// reporting

	task automatic report_mismatch(input string what, input logic [63:0] exp, input logic [63:0] act);
		$display("[FAIL] %s: %s expected 0x%0h actual 0x%0h", cur_test, what, exp, act);
		$display(">>> FAIL");
		$fatal(1);
	endtask

	task automatic report_error(input string what);
		$display("%s: %s", cur_test, what);
		$display(">>> FAIL");
		$fatal(1);
	endtask

	//////////////////// monitors

	// a word is taken at the edge that ends a beat
	always @(posedge ioclk) begin
		cycle = cycle + 1;
		if (axis_rst_n && i_io_serdes.phase == serdes_pkg::last_phase &&
				as_is_tvalid && is_as_tready) begin
			exp_data.push_back(as_is_tdata);
			exp_keep.push_back(as_is_tkeep);
			exp_last.push_back(as_is_tlast);
			exp_cycle.push_back(cycle);
			accepted = accepted + 1;
		end
	end

	always @(negedge ioclk) begin
		if (is_as_tvalid) begin
			assert (exp_data.size() > 0) else report_error("strobe with no word in flight");
			assert (cycle - exp_cycle[0] == latency)
				else report_mismatch("latency", latency, cycle - exp_cycle[0]);
			assert (is_as_tdata == exp_data[0]) else report_mismatch("tdata", exp_data[0], is_as_tdata);
			assert (is_as_tkeep == exp_keep[0]) else report_mismatch("tkeep", exp_keep[0], is_as_tkeep);
			assert (is_as_tlast == exp_last[0]) else report_mismatch("tlast", exp_last[0], is_as_tlast);
			void'(exp_data.pop_front());
			void'(exp_keep.pop_front());
			void'(exp_last.pop_front());
			void'(exp_cycle.pop_front());
		end
	end

	//////////////////// bus and stream tasks

	task automatic wb_access(input logic we, input logic [3:0] adr, input logic [31:0] data,
			output logic [31:0] rdata);
		int n;
		@(negedge ioclk);
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_dat_w = data;
		wb_sel   = 4'hf;
		n = 0;
		do begin
			@(negedge ioclk);
			n++;
			if (n > 8) report_error("no wishbone ack");
		end while (!wb_ack);
		rdata  = wb_dat_r;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	// offer one random word and hold it until it is taken
	task automatic send_words(input int count);
		int start;
		int n;
		for (int w = 0; w < count; w++) begin
			as_is_tdata  = $urandom;
			as_is_tkeep  = $urandom;
			as_is_tlast  = $urandom;
			as_is_tvalid = 1'b1;
			start = accepted;
			n = 0;
			do begin
				@(negedge ioclk);
				n++;
				if (n > wait_limit) report_error("word never accepted");
			end while (accepted == start);
		end
		as_is_tvalid = 1'b0;
	endtask

	task automatic wait_ready(input logic level, input int limit);
		int n;
		n = 0;
		while (is_as_tready !== level) begin
			@(negedge ioclk);
			n++;
			if (n > limit) report_error("is_as_tready did not reach the expected level");
		end
	endtask

	task automatic wait_reset_done(input int limit);
		int n;
		n = 0;
		while (!axis_rst_n) begin
			@(posedge ioclk);
			n++;
			if (n > limit) report_error("reset was never released");
		end
	endtask

	task automatic throttle_far_side();
		int snap;
		repeat (10) @(negedge ioclk);
		as_is_tready = 1'b0;
		wait_ready(1'b0, fall_limit);
		snap = accepted;
		repeat (24) begin
			@(negedge ioclk);
			assert (accepted == snap) else report_mismatch("accepted while stalled", snap, accepted);
		end
		as_is_tready = 1'b1;
	endtask

	task automatic drain();
		int n;
		n = 0;
		while (exp_data.size() != 0) begin
			@(negedge ioclk);
			n++;
			if (n > wait_limit) report_error("words lost in flight");
		end
	endtask

	//////////////////// sequence

	initial begin
		seed_val     = $urandom(32'h0d3cd85d);
		cycle        = 0;
		accepted     = 0;
		cur_test     = "reset";
		wb_cyc       = 1'b0;
		wb_stb       = 1'b0;
		wb_we        = 1'b0;
		wb_adr       = '0;
		wb_dat_w     = '0;
		wb_sel       = '0;
		as_is_tdata  = '0;
		as_is_tkeep  = '0;
		as_is_tlast  = 1'b0;
		as_is_tvalid = 1'b0;
		as_is_tready = 1'b1;

		wait_ready(1'b0, 1);
		wait_reset_done(16);
		repeat (4) @(negedge ioclk);

		cur_test = "registers";
		wb_access(1'b1, serdes_reg_pkg::ctrl_addr, 32'h1, rd_data);  // rxen only
		wb_access(1'b0, serdes_reg_pkg::ctrl_addr, 32'h0, rd_data);
		assert (rd_data == 32'h1) else report_mismatch("ctrl rxen", 32'h1, rd_data);
		wb_access(1'b0, 4'h5, 32'h0, rd_data);
		assert (rd_data == 32'h0) else report_mismatch("unmapped read", 0, rd_data);

		cur_test = "bring-up";
		repeat (12) begin
			@(negedge ioclk);
			assert (!is_as_tready) else report_mismatch("ready before txen", 0, is_as_tready);
		end
		wb_access(1'b1, serdes_reg_pkg::ctrl_addr, 32'h3, rd_data);
		wb_access(1'b0, serdes_reg_pkg::ctrl_addr, 32'h0, rd_data);
		assert (rd_data == 32'h3) else report_mismatch("ctrl both", 32'h3, rd_data);
		wait_ready(1'b1, 16);

		cur_test = "loopback";
		send_words(20);
		drain();

		cur_test = "flow control";
		fork
			send_words(12);
			throttle_far_side();
		join
		drain();

		if (exp_data.size() == 0 && accepted == 32) begin
			$display(">>> PASS");
			$finish;
		end else begin
			report_error("word count mismatch at end of run");
		end
	end

endmodule

`default_nettype wire

/* io_serdes.f */
logic/serdes_pkg.sv
logic/serdes_reg_pkg.sv
logic/serdes_regs.sv
logic/serdes_link_ctrl.sv
logic/serdes_tx.sv
logic/serdes_rx_lane.sv
logic/serdes_rx_merge.sv
logic/io_serdes.sv
sim/io_serdes_clkgen.sv
sim/io_serdes_checker.sv
sim/io_serdes_tb.sv

/* Bender.yml */
package:
  name: io_serdes

sources:
  - files:
      - logic/serdes_pkg.sv
      - logic/serdes_reg_pkg.sv
      - logic/serdes_regs.sv
      - logic/serdes_link_ctrl.sv
      - logic/serdes_tx.sv
      - logic/serdes_rx_lane.sv
      - logic/serdes_rx_merge.sv
      - logic/io_serdes.sv
  - target: simulation
    files:
      - sim/io_serdes_clkgen.sv
      - sim/io_serdes_checker.sv
      - sim/io_serdes_tb.sv
